// ==== hdl/wvb_pkg.sv ====
// waveform buffer types, header bundle layout and format-0 constants
package wvb_pkg;

  // sample memory address, 4096 deep
  typedef logic [11:0] wvb_addr_t;
  // local time counter, 60 MHz
  typedef logic [47:0] ltc_t;
  // raw sample word: discr[21:14], adc[13:2], tot[1], eoe[0]
  typedef logic [21:0] smp_word_t;
  // format-2 header bundle
  typedef logic [81:0] hdr_bundle_t;
  // event length in samples
  typedef logic [15:0] evt_len_t;
  // sign extended adc value
  typedef logic [15:0] adc_word_t;

  // header bundle field positions, from the top bit down
  localparam int L_HDR_LTC_HI   = 81;
  localparam int L_HDR_LTC_ODD  = 33;
  localparam int L_HDR_START_HI = 32;
  localparam int L_HDR_START_LO = 21;
  localparam int L_HDR_STOP_HI  = 20;
  localparam int L_HDR_STOP_LO  = 9;
  localparam int L_HDR_TRIG_HI  = 8;
  localparam int L_HDR_TRIG_LO  = 7;
  localparam int L_HDR_CNST     = 6;
  localparam int L_HDR_PCFG_HI  = 5;
  localparam int L_HDR_PCFG_LO  = 1;
  localparam int L_HDR_SYNC     = 0;

  // sample word field positions
  localparam int L_SMP_DISCR_LO = 14;
  localparam int L_SMP_ADC_HI   = 13;
  localparam int L_SMP_ADC_LO   = 2;
  localparam int L_SMP_TOT      = 1;

  // format byte in the channel word
  localparam logic [7:0] L_FMT_0 = 8'h90;
  // cycles from an rdreq cycle to its decoded sample
  localparam int L_SMP_LAT = 2;

endpackage

// ==== hdl/dpram_pkg.sv ====
// readout RAM address and word types
// plus the address limits used by the format-0 writer
package dpram_pkg;

  typedef logic [9:0]  dpram_addr_t;
  typedef logic [31:0] dpram_word_t;
  // reader side addresses count 16-bit words
  typedef logic [10:0] rd_addr_t;
  typedef logic [15:0] half_word_t;

  // mode 0, last sample slot, the footer takes the next one
  localparam dpram_addr_t L_A_LAST_DATA = 10'd1021;
  // mode 1, last sample slot before pausing for the next fill
  localparam dpram_addr_t L_A_LAST_CONT = 10'd1022;
  localparam dpram_addr_t L_A_LAST      = 10'd1023;
  // a fetch issued from slot d is written at d+4
  // (fetch latency plus the rdreq and write registers)
  localparam dpram_addr_t L_A_STOP_STREAM =
    L_A_LAST_CONT - dpram_addr_t'(wvb_pkg::L_SMP_LAT + 3);
  // refill wait before writing resumes in mode 1
  localparam int L_REFILL_CNT = 4;

endpackage

// ==== hdl/wvb_ifs.sv ====
// header field interface, unpacker to controller and streamer
// sample interface, controller to streamer

interface wvb_hdr_if;
  import wvb_pkg::*;

  wvb_addr_t   start_addr;
  wvb_addr_t   stop_addr;
  evt_len_t    evt_len;
  ltc_t        evt_ltc;
  logic [15:0] hdr_0_word;
  logic [7:0]  chan_idx;
  // controller is writing an event
  logic        busy;

  modport src (output start_addr, stop_addr, evt_len, evt_ltc, hdr_0_word, chan_idx,
               input busy);
  modport ctrl (input evt_len, evt_ltc, hdr_0_word, chan_idx, output busy);
  modport strm (input start_addr, stop_addr);
endinterface

interface wvb_smp_if;
  import wvb_pkg::*;

  logic       rdreq;
  logic       rddone;
  adc_word_t  adc;
  logic [7:0] discr;
  logic       tot;
  logic       eoe;

  modport ctrl (output rdreq, rddone, input adc, discr, tot, eoe);
  modport strm (input rdreq, rddone, output adc, discr, tot, eoe);
endinterface

// ==== hdl/wvb_hdr_unpack.sv ====
// header bundle unpacker
// registers the fields, the event length and the header-0 word
module wvb_hdr_unpack (
  input  logic                clk,
  input  logic                rst,
  input  wvb_pkg::hdr_bundle_t hdr_data,
  input  logic [7:0]          idx,
  wvb_hdr_if.src              hdr
);
  import wvb_pkg::*;

  wvb_addr_t start_w;
  wvb_addr_t stop_w;
  wvb_addr_t len_w;

  assign start_w = hdr_data[L_HDR_START_HI:L_HDR_START_LO];
  assign stop_w  = hdr_data[L_HDR_STOP_HI:L_HDR_STOP_LO];
  // length wraps with the sample address
  assign len_w   = stop_w - start_w + 12'd1;

  always_ff @(posedge clk) begin
    hdr.start_addr <= start_w;
    hdr.stop_addr  <= stop_w;
    hdr.evt_len    <= evt_len_t'(len_w);
    // 60 MHz ltc sits above the odd 120 MHz bit
    hdr.evt_ltc    <= hdr_data[L_HDR_LTC_HI:L_HDR_LTC_ODD+1];
    // preconf, cnst run, 6 zeros, sync rdy, odd ltc, trig src
    hdr.hdr_0_word <= {hdr_data[L_HDR_PCFG_HI:L_HDR_PCFG_LO],
                       hdr_data[L_HDR_CNST],
                       6'b0,
                       hdr_data[L_HDR_SYNC],
                       hdr_data[L_HDR_LTC_ODD],
                       hdr_data[L_HDR_TRIG_HI:L_HDR_TRIG_LO]};
    hdr.chan_idx   <= idx;
  end

  // streamer and controller rely on a frozen address window per event
  a_window_stable: assert property (@(posedge clk) disable iff (rst)
    hdr.busy && $past(hdr.busy) |-> $stable(hdr.start_addr) && $stable(hdr.stop_addr))
    else $error("header window changed during readout");

endmodule

// ==== hdl/wvb_sample_stream.sv ====
// sample memory with a streaming read head
// two-stage output decodes adc, discriminator, tot and eoe
module wvb_sample_stream (
  input  logic               clk,
  input  logic               rst,
  input  logic               smp_wr_en,
  input  wvb_pkg::wvb_addr_t smp_wr_addr,
  input  wvb_pkg::smp_word_t smp_wr_data,
  wvb_hdr_if.strm            hdr,
  wvb_smp_if.strm            smp
);
  import wvb_pkg::*;

  smp_word_t mem [0:4095];
  wvb_addr_t head;
  logic      active;
  smp_word_t word_q;
  logic      eoe_q;
  logic      eoe_seen;

  // loading port
  always_ff @(posedge clk) begin
    if (smp_wr_en) begin
      mem[smp_wr_addr] <= smp_wr_data;
    end
  end

  // read head
  always_ff @(posedge clk) begin
    if (rst) begin
      head   <= '0;
      active <= 1'b0;
    end else if (smp.rddone) begin
      // event finished, park on the next window
      head   <= hdr.start_addr;
      active <= 1'b0;
    end else if (smp.rdreq) begin
      // 12-bit head wraps modulo 4096
      head   <= head + 12'd1;
      active <= 1'b1;
    end else if (!active) begin
      head <= hdr.start_addr;
    end
  end

  // stage 1, memory read
  always_ff @(posedge clk) begin
    word_q <= mem[head];
  end

  // eoe only flags fetches the controller asked for
  always_ff @(posedge clk) begin
    if (rst) begin
      eoe_q   <= 1'b0;
      smp.eoe <= 1'b0;
    end else begin
      eoe_q   <= smp.rdreq && (head == hdr.stop_addr);
      smp.eoe <= eoe_q;
    end
  end

  // stage 2, decode
  // raw eoe bit [0] is replaced by the stop address match
  always_ff @(posedge clk) begin
    smp.adc   <= adc_word_t'(signed'(word_q[L_SMP_ADC_HI:L_SMP_ADC_LO]));
    smp.discr <= word_q[$bits(smp_word_t)-1:L_SMP_DISCR_LO];
    smp.tot   <= word_q[L_SMP_TOT];
  end

  // tracks an eoe not yet closed by rddone
  always_ff @(posedge clk) begin
    if (rst || smp.rddone) begin
      eoe_seen <= 1'b0;
    end else if (smp.eoe) begin
      eoe_seen <= 1'b1;
    end
  end

  a_no_read_past_eoe: assert property (@(posedge clk) disable iff (rst)
    eoe_seen |-> !smp.rdreq)
    else $error("rdreq after eoe without rddone");

endmodule

// ==== hdl/wvb_rd_ctrl_fmt_0.sv ====
// format-0 readout controller
// writes channel/len, hdr0/ltc, samples and footer into the readout RAM
// mode 0 truncates at one RAM, mode 1 continues over several fills
module wvb_rd_ctrl_fmt_0 (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req,
  input  logic                   dpram_mode,
  output logic                   ack,
  output logic                   rd_ctrl_more,
  wvb_hdr_if.ctrl                hdr,
  wvb_smp_if.ctrl                smp,
  output dpram_pkg::dpram_addr_t dpram_a,
  output dpram_pkg::dpram_word_t dpram_data,
  output logic                   dpram_wren,
  output dpram_pkg::half_word_t  dpram_len
);
  import wvb_pkg::*;
  import dpram_pkg::*;

  typedef enum logic [3:0] {
    S_IDLE,
    S_START_STREAM,
    S_CHAN_LEN,
    S_HDR0_LTC2,
    S_LTC1_LTC0,
    S_SAMPLE,
    S_FTR,
    S_ACK,
    S_REQ_WAIT,
    S_REFILL
  } state_t;

  state_t      state;
  dpram_addr_t nxt_a;
  dpram_addr_t stream_lim;
  logic        loop_ftr;
  logic [2:0]  refill_cnt;
  evt_len_t    evt_len_reg;
  logic [15:0] hdr_0_reg;

  assign nxt_a = dpram_a + 10'd1;
  // mode 1 holds one more sample slot before pausing
  assign stream_lim = dpram_mode ? L_A_STOP_STREAM + 10'd1 : L_A_STOP_STREAM;

  assign hdr.busy = (state != S_IDLE) && (state != S_ACK) && (state != S_REQ_WAIT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_IDLE;
      ack          <= 1'b0;
      rd_ctrl_more <= 1'b0;
      smp.rdreq    <= 1'b0;
      smp.rddone   <= 1'b0;
      dpram_a      <= '0;
      dpram_wren   <= 1'b0;
      dpram_len    <= '0;
      loop_ftr     <= 1'b0;
      refill_cnt   <= '0;
    end else begin
      // pulses default low
      ack        <= 1'b0;
      dpram_wren <= 1'b0;
      smp.rddone <= 1'b0;
      smp.rdreq  <= 1'b0;

      case (state)
        S_IDLE: begin
          dpram_a      <= '0;
          dpram_len    <= '0;
          rd_ctrl_more <= 1'b0;
          loop_ftr     <= 1'b0;
          if (req) begin
            state <= S_START_STREAM;
          end
        end

        S_START_STREAM: begin
          // freeze the words reused by the footer
          evt_len_reg <= hdr.evt_len;
          hdr_0_reg   <= hdr.hdr_0_word;
          state       <= S_CHAN_LEN;
        end

        S_CHAN_LEN: begin
          // first fetch lines up with the first sample slot
          smp.rdreq  <= 1'b1;
          dpram_data <= {evt_len_reg, L_FMT_0, hdr.chan_idx};
          dpram_wren <= 1'b1;
          state      <= S_HDR0_LTC2;
        end

        S_HDR0_LTC2: begin
          smp.rdreq  <= 1'b1;
          dpram_data <= {hdr.evt_ltc[47:32], hdr_0_reg};
          dpram_wren <= 1'b1;
          dpram_a    <= nxt_a;
          state      <= S_LTC1_LTC0;
        end

        S_LTC1_LTC0: begin
          smp.rdreq  <= 1'b1;
          dpram_data <= {hdr.evt_ltc[15:0], hdr.evt_ltc[31:16]};
          dpram_wren <= 1'b1;
          dpram_a    <= nxt_a;
          state      <= S_SAMPLE;
        end

        S_SAMPLE: begin
          dpram_data <= {smp.discr, 6'b0, smp.tot, smp.eoe, smp.adc};
          dpram_wren <= 1'b1;
          dpram_a    <= nxt_a;
          if (smp.eoe) begin
            smp.rddone <= 1'b1;
            state      <= S_FTR;
          end else if (!dpram_mode && nxt_a == L_A_LAST_DATA) begin
            // truncate, the footer takes the next slot
            smp.rddone <= 1'b1;
            state      <= S_FTR;
          end else if (dpram_mode && nxt_a == L_A_LAST_CONT) begin
            rd_ctrl_more <= 1'b1;
            state        <= S_ACK;
          end else if (dpram_a <= stream_lim || dpram_a >= L_A_LAST_CONT) begin
            // upper slots only occur right after a refill
            smp.rdreq <= 1'b1;
          end
        end

        S_FTR: begin
          if (dpram_a != L_A_LAST || loop_ftr) begin
            dpram_data   <= {hdr_0_reg, evt_len_reg};
            dpram_wren   <= 1'b1;
            dpram_a      <= nxt_a;
            loop_ftr     <= 1'b0;
            rd_ctrl_more <= 1'b0;
          end else begin
            // footer would wrap to 0, send it in the next fill
            loop_ftr     <= 1'b1;
            rd_ctrl_more <= 1'b1;
          end
          state <= S_ACK;
        end

        S_ACK: begin
          // length in 16-bit words
          dpram_len <= (half_word_t'(dpram_a) + 16'd1) << 1;
          ack       <= 1'b1;
          if (!req) begin
            ack       <= 1'b0;
            dpram_len <= '0;
            state     <= rd_ctrl_more ? S_REQ_WAIT : S_IDLE;
          end
        end

        S_REQ_WAIT: begin
          if (req) begin
            refill_cnt <= '0;
            state      <= loop_ftr ? S_FTR : S_REFILL;
          end
        end

        S_REFILL: begin
          refill_cnt <= refill_cnt + 3'd1;
          // restart fetches so the next sample is ready on the first write
          if (refill_cnt >= 3'(L_REFILL_CNT - L_SMP_LAT)) begin
            smp.rdreq <= 1'b1;
          end
          if (refill_cnt == 3'(L_REFILL_CNT)) begin
            state <= S_SAMPLE;
          end
        end

        default: state <= S_IDLE;
      endcase
    end
  end

  // the RAM belongs to the writer only while req is held and ack is low
  a_no_wr_during_ack: assert property (@(posedge clk) disable iff (rst)
    dpram_wren |-> req && !ack)
    else $error("RAM write outside the req window or during ack");

endmodule

// ==== hdl/readout_dpram.sv ====
// readout RAM, 1024 x 32
// 32-bit write port, 16-bit registered read port
module readout_dpram (
  input  logic                   clk,
  input  logic                   wren,
  input  dpram_pkg::dpram_addr_t wr_addr,
  input  dpram_pkg::dpram_word_t wr_data,
  input  dpram_pkg::rd_addr_t    rd_addr,
  output dpram_pkg::half_word_t  rd_data
);
  import dpram_pkg::*;

  dpram_word_t mem [0:1023];
  dpram_word_t rd_word;

  always_ff @(posedge clk) begin
    if (wren) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // word index is the upper 10 bits of the half-word address
  assign rd_word = mem[rd_addr[10:1]];

  // even address gives the low half, odd the high half
  always_ff @(posedge clk) begin
    if (rd_addr[0]) begin
      rd_data <= rd_word[31:16];
    end else begin
      rd_data <= rd_word[15:0];
    end
  end

endmodule

// ==== hdl/wvb_readout_top.sv ====
// waveform buffer readout top level
// header unpacker and sample streamer feed the format-0 writer and RAM
module wvb_readout_top (
  input  logic                  clk,
  input  logic                  rst,
  // sample loading
  input  logic                  smp_wr_en,
  input  wvb_pkg::wvb_addr_t    smp_wr_addr,
  input  wvb_pkg::smp_word_t    smp_wr_data,
  // event header
  input  wvb_pkg::hdr_bundle_t  hdr_data,
  input  logic [7:0]            idx,
  // reader handshake
  input  logic                  req,
  input  logic                  dpram_mode,
  output logic                  ack,
  output logic                  rd_ctrl_more,
  output logic                  rddone,
  // RAM read port
  input  dpram_pkg::rd_addr_t   rd_addr,
  output dpram_pkg::half_word_t rd_data,
  output dpram_pkg::half_word_t dpram_len
);
  import dpram_pkg::*;

  dpram_addr_t dpram_a;
  dpram_word_t dpram_data;
  logic        dpram_wren;

  wvb_hdr_if hdr_bus ();
  wvb_smp_if smp_bus ();

  assign rddone = smp_bus.rddone;

  wvb_hdr_unpack u_hdr_unpack (
    .clk      (clk),
    .rst      (rst),
    .hdr_data (hdr_data),
    .idx      (idx),
    .hdr      (hdr_bus.src)
  );

  wvb_sample_stream u_sample_stream (
    .clk         (clk),
    .rst         (rst),
    .smp_wr_en   (smp_wr_en),
    .smp_wr_addr (smp_wr_addr),
    .smp_wr_data (smp_wr_data),
    .hdr         (hdr_bus.strm),
    .smp         (smp_bus.strm)
  );

  wvb_rd_ctrl_fmt_0 u_rd_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .dpram_mode   (dpram_mode),
    .ack          (ack),
    .rd_ctrl_more (rd_ctrl_more),
    .hdr          (hdr_bus.ctrl),
    .smp          (smp_bus.ctrl),
    .dpram_a      (dpram_a),
    .dpram_data   (dpram_data),
    .dpram_wren   (dpram_wren),
    .dpram_len    (dpram_len)
  );

  readout_dpram u_dpram (
    .clk     (clk),
    .wren    (dpram_wren),
    .wr_addr (dpram_a),
    .wr_data (dpram_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

// ==== tb/wvb_readout_tb.sv ====
// testbench for the format-0 waveform buffer readout
// LCG events, RAM readback over the 16-bit port, assertion checks
module wvb_readout_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 5000;

  logic        clk;
  logic        rst;
  logic        smp_wr_en;
  logic [11:0] smp_wr_addr;
  logic [21:0] smp_wr_data;
  logic [81:0] hdr_data;
  logic [7:0]  idx;
  logic        req;
  logic        dpram_mode;
  logic        ack;
  logic        rd_ctrl_more;
  logic        rddone;
  logic [10:0] rd_addr;
  logic [15:0] rd_data;
  logic [15:0] dpram_len;

  int unsigned rng_state = 76639;
  int          value_errs = 0;
  int          proto_errs = 0;
  int          timeouts = 0;
  int          rddone_cnt;
  bit          req_seen = 1'b0;
  // reference copy of the sample memory and the current event
  logic [21:0] ref_smp [0:4095];
  logic [15:0] hdr_exp [0:5];
  logic [11:0] ev_start;
  int          ev_n;
  int          ev_total;
  int          smp_pos;

  wvb_readout_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst) begin
      rddone_cnt <= 0;
    end else if (rddone) begin
      rddone_cnt <= rddone_cnt + 1;
    end
  end

  // outputs quiet between reset and the first req
  a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
    !req_seen |-> !ack && !rd_ctrl_more && !rddone && dpram_len == 16'h0)
    else begin
      proto_errs++;
      $display("Error: ack %h rd_ctrl_more %h rddone %h dpram_len %h before first req",
               $sampled(ack), $sampled(rd_ctrl_more), $sampled(rddone), $sampled(dpram_len));
    end

  a_ack_held: assert property (@(posedge clk) disable iff (rst) ack && req |=> ack)
    else begin
      proto_errs++;
      $display("ack dropped while req was still held");
    end

  // ack and the length clear together once req is gone
  a_ack_release: assert property (@(posedge clk) disable iff (rst)
    ack && !req |=> !ack && dpram_len == 16'h0)
    else begin
      proto_errs++;
      $display("ack or dpram_len did not clear after req fell");
    end

  function logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      value_errs++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // one registered read, address driven on the falling edge
  task automatic check_half(input logic [10:0] a, input logic [15:0] exp);
    rd_addr = a;
    @(negedge clk);
    check_value($sformatf("rd_data[%0d]", a), rd_data, exp);
  endtask

  task automatic wait_ack(input logic level);
    int cnt;
    cnt = 0;
    while (ack !== level && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (ack !== level) begin
      timeouts++;
      $display("timed out waiting for ack to become %0d", level);
    end
  endtask

  // random header; hdr_0 is preconf, cnst run, zeros, sync, odd ltc, trig
  task automatic drive_header(input logic [11:0] start, input int n);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [47:0] ltc;
    logic [11:0] stop;
    r0 = next_rand();
    r1 = next_rand();
    r2 = next_rand();
    ltc = {r0[31:16], r1};
    stop = start + 12'(n - 1);
    idx = r2[31:24];
    hdr_data = {ltc, r2[23], start, stop, r2[22:21], r2[20], r2[19:15], r2[14]};
    hdr_exp[0] = {8'h90, r2[31:24]};
    // event length is the sample count
    hdr_exp[1] = 16'(n);
    hdr_exp[2] = {r2[19:15], r2[20], 6'b0, r2[14], r2[23], r2[22:21]};
    hdr_exp[3] = ltc[47:32];
    hdr_exp[4] = ltc[31:16];
    hdr_exp[5] = ltc[15:0];
  endtask

  task automatic load_samples(input logic [11:0] start, input int n);
    logic [31:0] r;
    logic [11:0] a;
    for (int i = 0; i < n; i++) begin
      r = next_rand();
      a = start + 12'(i);
      ref_smp[a] = r[31:10];
      smp_wr_en = 1'b1;
      smp_wr_addr = a;
      smp_wr_data = r[31:10];
      @(negedge clk);
    end
    smp_wr_en = 1'b0;
  endtask

  // first fill holds header, samples 3..1021 (mode 0) or 3..1022 (mode 1)
  // later fills start at 1023 and wrap to 0
  task automatic read_fill(input bit first, output bit more);
    int rem;
    int cap;
    int nsmp;
    int nw;
    logic ftr;
    logic more_exp;
    logic [9:0] wa;
    logic [21:0] w;
    logic last;
    rem = ev_total - smp_pos;
    cap = first ? (dpram_mode ? 1020 : 1019) : 1024;
    ftr = (rem <= cap);
    nsmp = ftr ? rem : cap;
    more_exp = !ftr;
    // the DUT decides whether another fill follows
    more = rd_ctrl_more;
    nw = (first ? 3 : 0) + nsmp + int'(ftr);
    check_value("dpram_len", dpram_len, 16'(2 * (first ? nw : nw - 1)));
    check_value("rd_ctrl_more", {15'b0, rd_ctrl_more}, {15'b0, more_exp});
    for (int k = 0; k < nw; k++) begin
      wa = first ? 10'(k) : 10'(k + 1023);
      if (first && k < 3) begin
        check_half({wa, 1'b0}, hdr_exp[2 * k]);
        check_half({wa, 1'b1}, hdr_exp[2 * k + 1]);
      end else if (ftr && k == nw - 1) begin
        // footer repeats evt_len and hdr_0
        check_half({wa, 1'b0}, hdr_exp[1]);
        check_half({wa, 1'b1}, hdr_exp[2]);
      end else begin
        w = ref_smp[ev_start + 12'(smp_pos)];
        last = (smp_pos == ev_n - 1);
        check_half({wa, 1'b0}, {{4{w[13]}}, w[13:2]});
        check_half({wa, 1'b1}, {w[21:14], 6'b0, w[1], last});
        smp_pos++;
      end
    end
  endtask

  task automatic run_event(input logic mode, input int n);
    logic [31:0] r;
    int done_start;
    int fills;
    bit first;
    bit more;
    r = next_rand();
    ev_start = r[31:20];
    ev_n = n;
    // mode 0 keeps at most 1019 samples
    ev_total = (!mode && n > 1019) ? 1019 : n;
    smp_pos = 0;
    dpram_mode = mode;
    drive_header(ev_start, n);
    load_samples(ev_start, n);
    done_start = rddone_cnt;
    first = 1'b1;
    fills = 0;
    do begin
      req = 1'b1;
      req_seen = 1'b1;
      wait_ack(1'b1);
      read_fill(first, more);
      req = 1'b0;
      wait_ack(1'b0);
      first = 1'b0;
      fills++;
    end while (more && timeouts == 0 && fills < 8);
    check_value("sample count", 16'(smp_pos), 16'(ev_total));
    check_value("rddone pulses", 16'(rddone_cnt - done_start), 16'h1);
  endtask

  initial begin
    rst = 1'b1;
    smp_wr_en = 1'b0;
    smp_wr_addr = '0;
    smp_wr_data = '0;
    hdr_data = '0;
    idx = '0;
    req = 1'b0;
    dpram_mode = 1'b0;
    rd_addr = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    // idle stretch for the reset checks
    repeat (20) @(negedge clk);
    // short, then truncated mode 0 event
    run_event(1'b0, 40 + int'(next_rand() % 60));
    run_event(1'b0, 1500);
    // three fills: 1020, 1024 and 200 samples
    run_event(1'b1, 2244);
    run_event(1'b1, 100 + int'(next_rand() % 200));
    repeat (5) @(negedge clk);
    $display("value errors: %0d, protocol errors: %0d, timeouts: %0d",
             value_errs, proto_errs, timeouts);
    if (value_errs + proto_errs + timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== project.f ====
hdl/wvb_pkg.sv
hdl/dpram_pkg.sv
hdl/wvb_ifs.sv
hdl/wvb_hdr_unpack.sv
hdl/wvb_sample_stream.sv
hdl/wvb_rd_ctrl_fmt_0.sv
hdl/readout_dpram.sv
hdl/wvb_readout_top.sv
tb/wvb_readout_tb.sv
